// ==== ciSubsystem_params.svh ====
`ifndef CI_SUBSYSTEM_PARAMS_SVH
`define CI_SUBSYSTEM_PARAMS_SVH

// custom-instruction bus widths.
`define CI_WORD_WIDTH 32
`define CI_ID_WIDTH 8

// instruction numbers claimed by the units.
`define CI_ID_SWAP_BYTE 8'd1
`define CI_ID_MICRO_DELAY 8'd6

// delay unit, 100 ns system clock.
`define DELAY_WIDTH 16
`define CYCLES_PER_MICRO 10

// reset sequencer.
`define RESET_COUNT_WIDTH 5

`endif

// ==== ciPkg.sv ====
`include "ciSubsystem_params.svh"

package ciPkg;

  // operand word, seen whole or byte by byte.
  typedef union packed {
    logic [`CI_WORD_WIDTH-1:0]          word;
    logic [`CI_WORD_WIDTH/8-1:0][7:0]   bytes;
  } ciWord_t;

endpackage

// ==== customInstrIf.sv ====
`timescale 1ns/1ps
`include "ciSubsystem_params.svh"

interface customInstrIf
  import ciPkg::*;
();

  logic [`CI_ID_WIDTH-1:0] ciN;
  ciWord_t                 ciDataA;
  ciWord_t                 ciDataB;
  logic                    ciStart;

  // processor side drives the strobe bus.
  modport processor (
    output ciN,
    output ciDataA,
    output ciDataB,
    output ciStart
  );

  // each unit only listens.
  modport unit (
    input ciN,
    input ciDataA,
    input ciDataB,
    input ciStart
  );

endinterface

// ==== resetSequencer.sv ====
`timescale 1ns/1ps
`include "ciSubsystem_params.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReset_o
);

  logic [`RESET_COUNT_WIDTH-1:0] s_resetCountReg;
  logic                          s_resetDone;

  // top bit set means the sequence is over.
  assign s_resetDone = s_resetCountReg[`RESET_COUNT_WIDTH-1];

  // counts up after the lock, then holds.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      s_resetCountReg <= '0;
    end else if (~s_resetDone) begin
      s_resetCountReg <= s_resetCountReg + 1'b1;
    end
  end

  assign cpuReset_o = ~s_resetDone;

endmodule

// ==== byteSwapUnit.sv ====
`timescale 1ns/1ps
`include "ciSubsystem_params.svh"

module byteSwapUnit
  import ciPkg::*;
(
  input  logic         cpuReset_i,
  customInstrIf.unit   ciBus_i,
  output logic         done_o,
  output ciWord_t      result_o
);

  logic    s_select;
  logic    s_halfSwap;
  ciWord_t s_operand;
  ciWord_t s_swapped;

  // claimed only outside the processor reset.
  assign s_select = ciBus_i.ciStart & ~cpuReset_i &
                    (ciBus_i.ciN == `CI_ID_SWAP_BYTE);

  assign s_halfSwap = ciBus_i.ciDataB.word[0];
  assign s_operand  = ciBus_i.ciDataA;

  always_comb begin
    if (s_halfSwap) begin
      // halves exchanged, byte order kept.
      s_swapped.bytes[3] = s_operand.bytes[1];
      s_swapped.bytes[2] = s_operand.bytes[0];
      s_swapped.bytes[1] = s_operand.bytes[3];
      s_swapped.bytes[0] = s_operand.bytes[2];
    end else begin
      // full reverse.
      s_swapped.bytes[3] = s_operand.bytes[0];
      s_swapped.bytes[2] = s_operand.bytes[1];
      s_swapped.bytes[1] = s_operand.bytes[2];
      s_swapped.bytes[0] = s_operand.bytes[3];
    end
  end

  assign done_o        = s_select;
  // result must stay zero so it can be ORed onto the bus.
  assign result_o.word = s_select ? s_swapped.word : '0;

endmodule

// ==== microDelayUnit.sv ====
`timescale 1ns/1ps
`include "ciSubsystem_params.svh"

module microDelayUnit
  import ciPkg::*;
(
  input  logic         s_systemClock,
  input  logic         s_pllLocked,
  input  logic         cpuReset_i,
  customInstrIf.unit   ciBus_i,
  output logic         done_o,
  output ciWord_t      result_o
);

  // wide enough for the largest operand times the cycles per microsecond.
  localparam int countWidth = `DELAY_WIDTH + $clog2(`CYCLES_PER_MICRO);

  logic [`DELAY_WIDTH-1:0] s_delayMicros;
  logic [countWidth-1:0]   s_scaledCount;
  logic [countWidth-1:0]   s_loadValue;
  logic [countWidth-1:0]   s_countReg;
  logic                    s_busyReg;
  logic                    s_doneReg;
  logic                    s_startDelay;
  logic                    s_lastCycle;

  // new delays only accepted while idle.
  assign s_startDelay = ciBus_i.ciStart & ~s_busyReg &
                        (ciBus_i.ciN == `CI_ID_MICRO_DELAY);

  assign s_delayMicros = ciBus_i.ciDataA.word[`DELAY_WIDTH-1:0];
  assign s_scaledCount = countWidth'(s_delayMicros) *
                         countWidth'(`CYCLES_PER_MICRO);

  // zero microseconds still costs one cycle.
  assign s_loadValue = (s_delayMicros == '0) ? countWidth'(1) : s_scaledCount;

  assign s_lastCycle = s_busyReg & (s_countReg == countWidth'(1));

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      s_busyReg <= 1'b0;
    end else if (cpuReset_i) begin
      s_busyReg <= 1'b0;
    end else if (s_startDelay) begin
      s_busyReg <= 1'b1;
    end else if (s_lastCycle) begin
      s_busyReg <= 1'b0;
    end
  end

  // down-counter, loaded on an accepted start.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      s_countReg <= '0;
    end else if (cpuReset_i) begin
      s_countReg <= '0;
    end else if (s_startDelay) begin
      s_countReg <= s_loadValue;
    end else if (s_busyReg) begin
      s_countReg <= s_countReg - 1'b1;
    end
  end

  // single-cycle done at the end of the delay.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (~s_pllLocked) begin
      s_doneReg <= 1'b0;
    end else if (cpuReset_i) begin
      s_doneReg <= 1'b0;
    end else begin
      s_doneReg <= s_lastCycle;
    end
  end

  assign done_o = s_doneReg;

  // blocking delay returns nothing.
  assign result_o.word = '0;

endmodule

// ==== ciSubsystem.sv ====
`timescale 1ns/1ps
`include "ciSubsystem_params.svh"

module ciSubsystem
  import ciPkg::*;
(
  input  logic                      s_systemClock,
  input  logic                      s_pllLocked,
  input  logic [`CI_ID_WIDTH-1:0]   ciN_i,
  input  logic [`CI_WORD_WIDTH-1:0] ciDataA_i,
  input  logic [`CI_WORD_WIDTH-1:0] ciDataB_i,
  input  logic                      ciStart_i,
  output logic                      ciDone_o,
  output logic [`CI_WORD_WIDTH-1:0] ciResult_o,
  output logic                      cpuReset_o
);

  logic    s_cpuReset;
  logic    s_swapByteDone;
  logic    s_delayDone;
  ciWord_t s_swapByteResult;
  ciWord_t s_delayResult;

  // strobe bus shared by all units.
  customInstrIf ciBus ();

  // processor side of the bus comes straight from the ports.
  assign ciBus.ciN          = ciN_i;
  assign ciBus.ciDataA.word = ciDataA_i;
  assign ciBus.ciDataB.word = ciDataB_i;
  assign ciBus.ciStart      = ciStart_i;

  resetSequencer resetSeq (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .cpuReset_o    (s_cpuReset)
  );

  assign cpuReset_o = s_cpuReset;

  // instruction 1.
  byteSwapUnit swapByte (
    .cpuReset_i (s_cpuReset),
    .ciBus_i    (ciBus.unit),
    .done_o     (s_swapByteDone),
    .result_o   (s_swapByteResult)
  );

  // instruction 6.
  microDelayUnit delayMicro (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .cpuReset_i    (s_cpuReset),
    .ciBus_i       (ciBus.unit),
    .done_o        (s_delayDone),
    .result_o      (s_delayResult)
  );

  // idle units drive zero, so a plain OR merges them.
  assign ciDone_o   = s_swapByteDone | s_delayDone;
  assign ciResult_o = s_swapByteResult.word | s_delayResult.word;

endmodule

// ==== ciSubsystemTb.sv ====
`timescale 1ns/1ps
`include "ciSubsystem_params.svh"

module ciSubsystemTb;

  localparam int halfPeriod = 50;
  localparam int settleDelay = 25;
  localparam int rowCount = 10;

  typedef struct packed {
    logic [`CI_ID_WIDTH-1:0]   ciN;
    logic [`CI_WORD_WIDTH-1:0] dataA;
    logic                      mode;
    logic                      expectDone;
    logic [`DELAY_WIDTH-1:0]   delayMicros;
  } stimRow_t;

  logic                      s_systemClock;
  logic                      s_pllLocked;
  logic [`CI_ID_WIDTH-1:0]   ciN;
  logic [`CI_WORD_WIDTH-1:0] ciDataA;
  logic [`CI_WORD_WIDTH-1:0] ciDataB;
  logic                      ciStart;
  logic                      ciDone;
  logic [`CI_WORD_WIDTH-1:0] ciResult;
  logic                      cpuReset;

  stimRow_t    stimTable [rowCount];
  logic [31:0] lfsrState;
  int          resetEdges;

  ciSubsystem DUT (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciN_i         (ciN),
    .ciDataA_i     (ciDataA),
    .ciDataB_i     (ciDataB),
    .ciStart_i     (ciStart),
    .ciDone_o      (ciDone),
    .ciResult_o    (ciResult),
    .cpuReset_o    (cpuReset)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #halfPeriod s_systemClock = ~s_systemClock;
  end

  task automatic stopOnFailure(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkValue(input string signalName, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      stopOnFailure($sformatf("Error: %s is 0x%h, expected 0x%h", signalName, actual, expected));
    end
  endtask

  // galois form, one step per bit.
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  function automatic logic [31:0] nextRandomWord();
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < 32; i++) begin
      lfsrState = lfsrStep(lfsrState);
      word = {word[30:0], lfsrState[0]};
    end
    return word;
  endfunction

  // mode 0 reverses all bytes, mode 1 exchanges the halves.
  function automatic logic [31:0] expectedSwap(input logic [31:0] a, input logic mode);
    if (mode) begin
      return {a[15:0], a[31:16]};
    end
    return {a[7:0], a[15:8], a[23:16], a[31:24]};
  endfunction

  task automatic driveStart(input stimRow_t row);
    ciN     = row.ciN;
    ciDataA = row.dataA;
    ciDataB = {31'b0, row.mode};
    ciStart = 1'b1;
  endtask

  task automatic runSwap(input stimRow_t row);
    driveStart(row);
    #settleDelay;
    checkValue("ciDone_o", ciDone, 1);
    checkValue("ciResult_o", ciResult, expectedSwap(row.dataA, row.mode));
    @(negedge s_systemClock);
    ciStart = 1'b0;
    #settleDelay;
    checkValue("ciDone_o", ciDone, 0);
    checkValue("ciResult_o", ciResult, 0);
    @(negedge s_systemClock);
  endtask

  task automatic runDelay(input stimRow_t row, input bit restart);
    int edges;
    int expectedEdges;
    bit seenDone;
    expectedEdges = (row.delayMicros == 0) ? 1 : row.delayMicros * `CYCLES_PER_MICRO;
    edges = 0;
    seenDone = 1'b0;
    driveStart(row);
    // edges are counted after the one that samples the start.
    @(posedge s_systemClock);
    @(negedge s_systemClock);
    ciStart = 1'b0;
    checkValue("ciDone_o", ciDone, 0);
    checkValue("ciResult_o", ciResult, 0);
    while (!seenDone && edges < expectedEdges + 20) begin
      @(posedge s_systemClock);
      edges++;
      @(negedge s_systemClock);
      checkValue("ciResult_o", ciResult, 0);
      seenDone = ciDone;
      ciStart = 1'b0;
      // second start lands while the unit is busy.
      if (restart && edges == 5) begin
        ciDataA = 32'h0000_0001;
        ciStart = 1'b1;
      end
    end
    if (!seenDone) begin
      stopOnFailure("Timeout while waiting for done from the delay unit");
    end
    checkValue("ciDone_o edge count", edges, expectedEdges);
    @(posedge s_systemClock);
    @(negedge s_systemClock);
    checkValue("ciDone_o", ciDone, 0);
    if (restart) begin
      repeat (40) begin
        @(posedge s_systemClock);
        @(negedge s_systemClock);
        checkValue("ciDone_o", ciDone, 0);
      end
    end
  endtask

  task automatic runUnclaimed(input stimRow_t row);
    driveStart(row);
    #settleDelay;
    checkValue("ciDone_o", ciDone, 0);
    checkValue("ciResult_o", ciResult, 0);
    @(negedge s_systemClock);
    ciStart = 1'b0;
    repeat (50) begin
      @(posedge s_systemClock);
      @(negedge s_systemClock);
      checkValue("ciDone_o", ciDone, 0);
      checkValue("ciResult_o", ciResult, 0);
    end
  endtask

  initial begin
    s_pllLocked = 1'b0;
    ciN         = '0;
    ciDataA     = '0;
    ciDataB     = '0;
    ciStart     = 1'b0;
    lfsrState   = 32'h15c0_b7cf;
    resetEdges  = 0;

    // fixed words first, then random ones; delay rows carry noise above the count.
    stimTable[0] = '{`CI_ID_SWAP_BYTE, 32'h1122_3344, 1'b0, 1'b1, 16'd0};
    stimTable[1] = '{`CI_ID_SWAP_BYTE, 32'hdead_beef, 1'b1, 1'b1, 16'd0};
    stimTable[2] = '{`CI_ID_SWAP_BYTE, nextRandomWord(), 1'b0, 1'b1, 16'd0};
    stimTable[3] = '{`CI_ID_SWAP_BYTE, nextRandomWord(), 1'b1, 1'b1, 16'd0};
    stimTable[4] = '{`CI_ID_SWAP_BYTE, nextRandomWord(), 1'b0, 1'b1, 16'd0};
    stimTable[5] = '{`CI_ID_MICRO_DELAY, nextRandomWord() & 32'hffff_0000, 1'b0, 1'b1, 16'd0};
    stimTable[6] = '{`CI_ID_MICRO_DELAY, {16'h0, 16'd1}, 1'b1, 1'b1, 16'd1};
    stimTable[7] = '{`CI_ID_MICRO_DELAY, {16'ha5a5, 16'd3}, 1'b0, 1'b1, 16'd3};
    stimTable[8] = '{8'd4, nextRandomWord(), 1'b0, 1'b0, 16'd0};
    stimTable[9] = '{`CI_ID_SWAP_BYTE, 32'h0000_00ff, 1'b1, 1'b1, 16'd0};

    repeat (4) begin
      @(negedge s_systemClock);
      checkValue("cpuReset_o", cpuReset, 1);
      checkValue("ciDone_o", ciDone, 0);
      checkValue("ciResult_o", ciResult, 0);
    end
    s_pllLocked = 1'b1;

    // processor reset should drop on the 16th edge.
    while (cpuReset && resetEdges < 40) begin
      @(posedge s_systemClock);
      resetEdges++;
      @(negedge s_systemClock);
    end
    if (cpuReset) begin
      stopOnFailure("Timeout while waiting for the processor reset to end");
    end
    checkValue("cpuReset_o release edges", resetEdges, 16);

    for (int r = 0; r < rowCount; r++) begin
      if (!stimTable[r].expectDone) begin
        runUnclaimed(stimTable[r]);
      end else if (stimTable[r].ciN == `CI_ID_MICRO_DELAY) begin
        runDelay(stimTable[r], 1'b0);
      end else begin
        runSwap(stimTable[r]);
      end
    end

    runDelay(stimTable[7], 1'b1);

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
ciPkg.sv
customInstrIf.sv
resetSequencer.sv
byteSwapUnit.sv
microDelayUnit.sv
ciSubsystem.sv
ciSubsystemTb.sv

// ==== Bender.yml ====
package:
  name: ciSubsystem

sources:
  - include_dirs:
      - .
    files:
      - ciPkg.sv
      - customInstrIf.sv
      - resetSequencer.sv
      - byteSwapUnit.sv
      - microDelayUnit.sv
      - ciSubsystem.sv
      - target: test
        files:
          - ciSubsystemTb.sv
